// File: logic/mpeg_stream_pkg.sv
`default_nettype none

package mpeg_stream_pkg;

   // code bytes that follow the 00 00 01 prefix
   localparam logic [7:0] PACK_START_CODE  = 8'hBA;
   localparam logic [7:0] END_CODE         = 8'hB9;
   localparam logic [7:0] PRIVATE_STREAM_2 = 8'hBF;

   localparam logic [7:0] STUFFING_BYTE    = 8'hFF;

   // time-stamp codes, low nibble of the lead byte
   localparam logic [3:0] TS_NONE          = 4'b1111;  // whole lead byte is 0x0F
   localparam logic [3:0] TS_PTS_ONLY      = 4'b0010;
   localparam logic [3:0] TS_PTS_DTS       = 4'b0011;

   localparam int TIME_STAMP_WIDTH = 33;

   // one header byte, read either as the first STD byte or as a time-stamp lead
   typedef union packed
   {
      struct packed
      {
         logic [4:0] size_hi;
         logic       scale;
         logic [1:0] marker;   // 01 when an STD pair follows
      } std_view;

      struct packed
      {
         logic       zero;
         logic [2:0] ts_high;  // time stamp bits 32..30
         logic [3:0] code;
      } ts_view;
   } header_byte_u;

endpackage

`default_nettype wire

// File: logic/start_code_detector.sv
`timescale 1ns/100ps
`default_nettype none

module start_code_detector
(
   input  wire        read_signal,
   input  wire        reset,
   input  wire        prefix_armed,
   input  wire  [7:0] input_stream,
   output logic       prefix_found
);

   logic [1:0] zero_count;  // saturates at 2

   always_ff @(posedge read_signal)
   begin
      if (reset)
      begin
         zero_count   <= 2'd0;
         prefix_found <= 1'b0;
      end
      else
      begin
         prefix_found <= 1'b0;
         if (!prefix_armed)
         begin
            zero_count <= 2'd0;
         end
         else if (input_stream == 8'h00)
         begin
            // extra zeros before the 01 keep the prefix alive
            if (zero_count != 2'd2)
               zero_count <= zero_count + 2'd1;
         end
         else
         begin
            if (input_stream == 8'h01 && zero_count == 2'd2)
               prefix_found <= 1'b1;
            zero_count <= 2'd0;
         end
      end
   end

   // the count restarts after every 01, so two prefixes need at least three bytes
   assert property (@(posedge read_signal) disable iff (reset)
      prefix_found |=> !prefix_found);

endmodule

`default_nettype wire

// File: logic/time_stamp_parser.sv
`timescale 1ns/100ps
`default_nettype none

module time_stamp_parser
   import mpeg_stream_pkg::*;
(
   input  wire                         read_signal,
   input  wire                         reset,
   input  wire                         ts_begin,
   input  wire  [7:0]                  input_stream,
   output logic                        ts_done,
   output logic [TIME_STAMP_WIDTH-1:0] pts,
   output logic [TIME_STAMP_WIDTH-1:0] dts,
   output logic                        pts_valid,
   output logic                        dts_valid
);

   logic         busy;
   logic         with_dts;
   logic [3:0]   byte_idx;   // bytes after the lead, 1..9
   logic [3:0]   dts_pos;
   logic         lead_none;
   logic         lead_pts;
   logic         last_byte;
   header_byte_u cur_byte;

   assign cur_byte  = input_stream;
   assign dts_pos   = byte_idx - 4'd5;
   assign lead_none = ts_begin && !busy && input_stream == {4'h0, TS_NONE};
   assign lead_pts  = ts_begin && !busy && !cur_byte.ts_view.zero &&
                      (cur_byte.ts_view.code == TS_PTS_ONLY ||
                       cur_byte.ts_view.code == TS_PTS_DTS);
   assign last_byte = busy && ((byte_idx == 4'd4 && !with_dts) || byte_idx == 4'd9);

   // drops one byte of a 5-byte field into its place in the 33-bit value
   function automatic logic [TIME_STAMP_WIDTH-1:0] merge_ts(
      input logic [TIME_STAMP_WIDTH-1:0] ts,
      input logic [2:0]                  pos,
      input header_byte_u                b
   );
      logic [TIME_STAMP_WIDTH-1:0] r;
      r = ts;
      case (pos)
         3'd0: r[32:30] = b.ts_view.ts_high;
         3'd1: r[29:22] = b;
         3'd2: r[21:15] = b[6:0];   // top bit is a marker
         3'd3: r[14:7]  = b;
         default: r[6:0] = b[6:0];
      endcase
      return r;
   endfunction

   always_ff @(posedge read_signal)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         with_dts  <= 1'b0;
         byte_idx  <= 4'd0;
         ts_done   <= 1'b0;
         pts_valid <= 1'b0;
         dts_valid <= 1'b0;
      end
      else
      begin
         ts_done   <= 1'b0;
         pts_valid <= 1'b0;
         dts_valid <= 1'b0;
         if (lead_none)
         begin
            ts_done <= 1'b1;   // one-byte field, nothing to collect
         end
         else if (lead_pts)
         begin
            busy     <= 1'b1;
            with_dts <= (cur_byte.ts_view.code == TS_PTS_DTS);
            byte_idx <= 4'd1;
         end
         else if (busy)
         begin
            byte_idx <= byte_idx + 4'd1;
            if (last_byte)
            begin
               busy      <= 1'b0;
               ts_done   <= 1'b1;
               pts_valid <= 1'b1;
               dts_valid <= with_dts;
            end
         end
         // unknown codes leave the parser idle, no ts_done
      end
   end

   always_ff @(posedge read_signal)
   begin
      if (lead_pts)
         pts <= merge_ts(pts, 3'd0, cur_byte);
      else if (busy && byte_idx < 4'd5)
         pts <= merge_ts(pts, byte_idx[2:0], cur_byte);
      else if (busy)
         dts <= merge_ts(dts, dts_pos[2:0], cur_byte);   // second 5-byte group
   end

   // a field ends 1, 5 or 10 bytes after its lead byte
   assert property (@(posedge read_signal) disable iff (reset)
      ts_done |-> ($past(ts_begin) || $past(ts_begin, 5) || $past(ts_begin, 10)));

endmodule

`default_nettype wire

// File: logic/packet_reader.sv
`timescale 1ns/100ps
`default_nettype none

module packet_reader
   import mpeg_stream_pkg::*;
(
   input  wire        read_signal,
   input  wire        reset,
   input  wire        start,
   input  wire  [7:0] input_stream,
   input  wire        prefix_found,
   input  wire        ts_done,
   output logic       prefix_armed,
   output logic       ts_begin,
   output logic       done,
   output logic       stream_done,
   output logic [7:0] stream_id,
   output logic [7:0] buffer_out,
   output logic       byte_valid
);

   localparam logic [3:0] ST_IDLE    = 4'd0;
   localparam logic [3:0] ST_SEEK    = 4'd1;
   localparam logic [3:0] ST_CODE    = 4'd2;
   localparam logic [3:0] ST_LEN_HI  = 4'd3;
   localparam logic [3:0] ST_LEN_LO  = 4'd4;
   localparam logic [3:0] ST_HEADER  = 4'd5;
   localparam logic [3:0] ST_STD_LO  = 4'd6;
   localparam logic [3:0] ST_TS_LEAD = 4'd7;
   localparam logic [3:0] ST_TS_WAIT = 4'd8;
   localparam logic [3:0] ST_PAYLOAD = 4'd9;
   localparam logic [3:0] ST_ENDED   = 4'd10;

   logic [3:0]   state;
   logic [3:0]   cur_state;
   logic [15:0]  remaining;   // packet bytes still to come
   logic         last_byte;
   logic         stuffing;
   logic         std_lead;
   logic         take_payload;
   logic         is_packet;
   header_byte_u hdr;

   assign hdr = input_stream;

   // the code byte arrives in the cycle prefix_found is high, still in seek
   assign cur_state = (state == ST_SEEK && prefix_found) ? ST_CODE : state;

   assign last_byte    = (remaining <= 16'd1);
   assign stuffing     = (input_stream == STUFFING_BYTE);
   assign std_lead     = (hdr.std_view.marker == 2'b01);
   assign is_packet    = (input_stream != PACK_START_CODE) && (input_stream != END_CODE);
   assign take_payload = (cur_state == ST_PAYLOAD) || (cur_state == ST_TS_WAIT && ts_done);

   assign prefix_armed = (state == ST_SEEK) && start;
   assign ts_begin     = (cur_state == ST_TS_LEAD) ||
                         (cur_state == ST_HEADER && !stuffing && !std_lead);

   always_ff @(posedge read_signal)
   begin
      if (reset)
      begin
         state       <= ST_IDLE;
         done        <= 1'b0;
         stream_done <= 1'b0;
         byte_valid  <= 1'b0;
      end
      else
      begin
         done       <= 1'b0;
         byte_valid <= take_payload;
         case (cur_state)
            ST_IDLE:
               if (start)
                  state <= ST_SEEK;
            ST_SEEK:
               if (!start)
                  state <= ST_IDLE;
            ST_CODE:
               if (input_stream == PACK_START_CODE)
               begin
                  done <= 1'b1;   // pack body is skipped, keep seeking
               end
               else if (input_stream == END_CODE)
               begin
                  stream_done <= 1'b1;
                  state       <= ST_ENDED;
               end
               else
               begin
                  state <= ST_LEN_HI;
               end
            ST_LEN_HI:
               state <= ST_LEN_LO;
            ST_LEN_LO:
               if ({remaining[15:8], input_stream} == 16'd0)
                  state <= ST_SEEK;
               else if (stream_id == PRIVATE_STREAM_2)
                  state <= ST_PAYLOAD;   // no header fields
               else
                  state <= ST_HEADER;
            ST_HEADER:
               if (last_byte)
                  state <= ST_SEEK;
               else if (std_lead)
                  state <= ST_STD_LO;
               else if (!stuffing)
                  state <= ST_TS_WAIT;
            ST_STD_LO:
               state <= last_byte ? ST_SEEK : ST_TS_LEAD;
            ST_TS_LEAD:
               state <= last_byte ? ST_SEEK : ST_TS_WAIT;
            ST_TS_WAIT:
               if (last_byte)
                  state <= ST_SEEK;   // also the way out for a bad lead byte
               else if (ts_done)
                  state <= ST_PAYLOAD;
            ST_PAYLOAD:
               if (last_byte)
                  state <= ST_SEEK;
            ST_ENDED:
               if (!start)
               begin
                  stream_done <= 1'b0;
                  state       <= ST_IDLE;
               end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge read_signal)
   begin
      case (cur_state)
         ST_CODE:
            if (is_packet)
               stream_id <= input_stream;
         ST_LEN_HI:
            remaining[15:8] <= input_stream;
         ST_LEN_LO:
            remaining[7:0] <= input_stream;
         ST_HEADER, ST_STD_LO, ST_TS_LEAD, ST_TS_WAIT, ST_PAYLOAD:
            remaining <= remaining - 16'd1;
         default:
            ;
      endcase
      if (take_payload)
         buffer_out <= input_stream;
   end

   // bytes sampled between packets never show up as payload
   assert property (@(posedge read_signal) disable iff (reset)
      (state == ST_SEEK || state == ST_ENDED) |=> !byte_valid);

endmodule

`default_nettype wire

// File: logic/system_stream_parser.sv
`timescale 1ns/100ps
`default_nettype none

module system_stream_parser
   import mpeg_stream_pkg::*;
(
   input  wire                        read_signal,
   input  wire                        reset,
   input  wire                        start,
   input  wire  [7:0]                 input_stream,
   output wire                        done,
   output wire                        stream_done,
   output wire  [7:0]                 buffer_out,
   output wire                        byte_valid,
   output wire  [7:0]                 stream_id,
   output wire  [TIME_STAMP_WIDTH-1:0] pts,
   output wire  [TIME_STAMP_WIDTH-1:0] dts,
   output wire                        pts_valid,
   output wire                        dts_valid
);

   wire prefix_armed;
   wire prefix_found;
   wire ts_begin;
   wire ts_done;

   start_code_detector u_detector (
      .read_signal  (read_signal),
      .reset        (reset),
      .prefix_armed (prefix_armed),
      .input_stream (input_stream),
      .prefix_found (prefix_found)
   );

   time_stamp_parser u_ts_parser (
      .read_signal  (read_signal),
      .reset        (reset),
      .ts_begin     (ts_begin),
      .input_stream (input_stream),
      .ts_done      (ts_done),
      .pts          (pts),
      .dts          (dts),
      .pts_valid    (pts_valid),
      .dts_valid    (dts_valid)
   );

   packet_reader u_reader (
      .read_signal  (read_signal),
      .reset        (reset),
      .start        (start),
      .input_stream (input_stream),
      .prefix_found (prefix_found),
      .ts_done      (ts_done),
      .prefix_armed (prefix_armed),
      .ts_begin     (ts_begin),
      .done         (done),
      .stream_done  (stream_done),
      .stream_id    (stream_id),
      .buffer_out   (buffer_out),
      .byte_valid   (byte_valid)
   );

endmodule

`default_nettype wire

// File: tests/stream_vectors.svh
`ifndef STREAM_VECTORS_SVH
`define STREAM_VECTORS_SVH

// each row is one stream byte and the outputs expected once that byte is sampled
// columns: byte, start, byte_valid, buffer_out, done, stream_done, ts kind, pts, dts, stream_id
task automatic load_vectors();
   // reader leaves idle
   quiet_byte(8'h55);
   quiet_byte(8'h55);

   // pack start, then a short pack body that is skipped
   quiet_byte(8'h00);
   quiet_byte(8'h00);
   quiet_byte(8'h01);
   add_step(8'hBA, 1'b1, 1'b0, 8'h00, 1'b1, 1'b0, 2'd0, 33'd0, 33'd0, 8'h00);
   quiet_byte(8'h44);
   quiet_byte(8'h21);
   quiet_byte(8'h0F);
   quiet_byte(STUFFING_BYTE);

   // video packet, two stuffing bytes, 0x0F lead, three payload bytes
   quiet_byte(8'h00);
   quiet_byte(8'h00);
   quiet_byte(8'h01);
   quiet_byte(8'hE0);
   quiet_byte(8'h00);
   quiet_byte(8'h06);
   quiet_byte(STUFFING_BYTE);
   quiet_byte(STUFFING_BYTE);
   quiet_byte(8'h0F);
   expect_payload(8'hAA, 8'hE0);
   expect_payload(8'hBB, 8'hE0);
   expect_payload(8'hCC, 8'hE0);

   // STD pair then a 10-byte PTS and DTS field
   quiet_byte(8'h00);
   quiet_byte(8'h00);
   quiet_byte(8'h01);
   quiet_byte(8'hE1);
   quiet_byte(8'h00);
   quiet_byte(8'h0E);
   quiet_byte(8'h41);   // marker 01
   quiet_byte(8'h20);
   quiet_byte(8'h53);   // lead, code 0011
   quiet_byte(8'h12);
   quiet_byte(8'hB4);
   quiet_byte(8'h56);
   quiet_byte(8'hF9);
   quiet_byte(8'h31);
   quiet_byte(8'h9A);
   quiet_byte(8'h8B);
   quiet_byte(8'hCD);
   expect_ts(8'hEF, {3'b101, 8'h12, 7'h34, 8'h56, 7'h79},
             {3'b011, 8'h9A, 7'h0B, 8'hCD, 7'h6F});
   expect_payload(8'h77, 8'hE1);
   expect_payload(8'h88, 8'hE1);

   // broken prefixes, then a long run of zeros that does complete one
   quiet_byte(8'h00);
   quiet_byte(8'h05);
   quiet_byte(8'h00);
   quiet_byte(8'h01);
   quiet_byte(8'h44);
   quiet_byte(8'h00);
   quiet_byte(8'h00);
   quiet_byte(8'h00);
   quiet_byte(8'h01);
   add_step(8'hBA, 1'b1, 1'b0, 8'h00, 1'b1, 1'b0, 2'd0, 33'd0, 33'd0, 8'h00);
   quiet_byte(8'h55);
   quiet_byte(8'h55);
endtask

`endif

// File: tests/system_stream_parser_tb.sv
`timescale 1ns/100ps
`default_nettype none

module system_stream_parser_tb
   import mpeg_stream_pkg::*;
();

   logic                        read_signal;
   logic                        reset;
   logic                        start;
   logic [7:0]                  input_stream;
   wire                         done;
   wire                         stream_done;
   wire  [7:0]                  buffer_out;
   wire                         byte_valid;
   wire  [7:0]                  stream_id;
   wire  [TIME_STAMP_WIDTH-1:0] pts;
   wire  [TIME_STAMP_WIDTH-1:0] dts;
   wire                         pts_valid;
   wire                         dts_valid;

   logic [7:0]  vec_byte[$];
   logic        vec_start[$];
   logic        vec_bv[$];
   logic [7:0]  vec_bo[$];
   logic        vec_done[$];
   logic        vec_sdone[$];
   logic [1:0]  vec_ts[$];     // 0 none, 1 pts, 2 pts and dts
   logic [32:0] vec_pts[$];
   logic [32:0] vec_dts[$];
   logic [7:0]  vec_sid[$];
   logic [7:0]  sent[$];       // private stream bytes still owed
   logic [31:0] seed;

   system_stream_parser DUT (
      .read_signal  (read_signal),
      .reset        (reset),
      .start        (start),
      .input_stream (input_stream),
      .done         (done),
      .stream_done  (stream_done),
      .buffer_out   (buffer_out),
      .byte_valid   (byte_valid),
      .stream_id    (stream_id),
      .pts          (pts),
      .dts          (dts),
      .pts_valid    (pts_valid),
      .dts_valid    (dts_valid)
   );

   always #10 read_signal = ~read_signal;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
         $display("TB FAILED");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("TB FAILED");
      $fatal(1, "stopping on timeout");
   endtask

   task automatic add_step(input logic [7:0] b, input logic st, input logic bv,
                           input logic [7:0] bo, input logic dn, input logic sd,
                           input logic [1:0] ts, input logic [32:0] p,
                           input logic [32:0] d, input logic [7:0] sid);
      vec_byte.push_back(b);
      vec_start.push_back(st);
      vec_bv.push_back(bv);
      vec_bo.push_back(bo);
      vec_done.push_back(dn);
      vec_sdone.push_back(sd);
      vec_ts.push_back(ts);
      vec_pts.push_back(p);
      vec_dts.push_back(d);
      vec_sid.push_back(sid);
   endtask

   task automatic quiet_byte(input logic [7:0] b);
      add_step(b, 1'b1, 1'b0, 8'h00, 1'b0, 1'b0, 2'd0, 33'd0, 33'd0, 8'h00);
   endtask

   task automatic expect_payload(input logic [7:0] b, input logic [7:0] sid);
      add_step(b, 1'b1, 1'b1, b, 1'b0, 1'b0, 2'd0, 33'd0, 33'd0, sid);
   endtask

   task automatic expect_ts(input logic [7:0] b, input logic [32:0] p, input logic [32:0] d);
      add_step(b, 1'b1, 1'b0, 8'h00, 1'b0, 1'b0, 2'd2, p, d, 8'h00);
   endtask

   `include "stream_vectors.svh"

   task automatic check_step(input int i);
      check_value($sformatf("step %0d byte_valid", i), vec_bv[i], byte_valid);
      check_value($sformatf("step %0d done", i), vec_done[i], done);
      check_value($sformatf("step %0d stream_done", i), vec_sdone[i], stream_done);
      check_value($sformatf("step %0d pts_valid", i), vec_ts[i] != 2'd0, pts_valid);
      check_value($sformatf("step %0d dts_valid", i), vec_ts[i] == 2'd2, dts_valid);
      if (vec_bv[i])
      begin
         check_value($sformatf("step %0d buffer_out", i), vec_bo[i], buffer_out);
         check_value($sformatf("step %0d stream_id", i), vec_sid[i], stream_id);
      end
      if (vec_ts[i] != 2'd0)
         check_value($sformatf("step %0d pts", i), vec_pts[i], pts);
      if (vec_ts[i] == 2'd2)
         check_value($sformatf("step %0d dts", i), vec_dts[i], dts);
   endtask

   // drive on the rising edge, look at outputs half a period later
   task automatic drive_byte(input logic [7:0] b, input logic st);
      @(posedge read_signal);
      input_stream <= b;
      start        <= st;
      @(negedge read_signal);
   endtask

   task automatic observe_output(input string what);
      check_value({what, " done"}, 64'd0, done);
      if (byte_valid)
      begin
         if (sent.size() == 0)
         begin
            $display("unexpected payload byte %02h during %s", buffer_out, what);
            $display("TB FAILED");
            $fatal(1, "stopping at first error");
         end
         else
         begin
            check_value({what, " buffer_out"}, sent.pop_front(), buffer_out);
            check_value({what, " stream_id"}, PRIVATE_STREAM_2, stream_id);
         end
      end
   endtask

   initial
   begin
      int         cnt;
      logic [7:0] len;
      read_signal  = 1'b0;
      reset        = 1'b1;
      start        = 1'b0;
      input_stream = 8'h00;
      seed         = 32'hed04_2f83;
      load_vectors();
      repeat (5) @(posedge read_signal);
      reset <= 1'b0;

      // table, each row checked one cycle after it is driven
      for (int i = 0; i < vec_byte.size(); i++)
      begin
         @(posedge read_signal);
         input_stream <= vec_byte[i];
         start        <= vec_start[i];
         if (i > 0)
         begin
            @(negedge read_signal);
            check_step(i - 1);
         end
      end
      @(posedge read_signal);
      @(negedge read_signal);
      check_step(vec_byte.size() - 1);

      // private stream 2 with random length and payload
      seed = lcg_next(seed);
      len  = {4'h0, seed[19:16]} + 8'd1;
      drive_byte(8'h00, 1'b1);
      observe_output("ps2 header");
      drive_byte(8'h00, 1'b1);
      observe_output("ps2 header");
      drive_byte(8'h01, 1'b1);
      observe_output("ps2 header");
      drive_byte(PRIVATE_STREAM_2, 1'b1);
      observe_output("ps2 header");
      drive_byte(8'h00, 1'b1);
      observe_output("ps2 header");
      drive_byte(len, 1'b1);
      observe_output("ps2 header");
      for (int k = 0; k < len; k++)
      begin
         seed = lcg_next(seed);
         sent.push_back(seed[23:16]);
         drive_byte(seed[23:16], 1'b1);
         observe_output("ps2 payload");
      end
      cnt = 0;
      while (sent.size() != 0)
      begin
         if (cnt == 40)
            report_timeout("private stream payload");
         else
         begin
            drive_byte(8'h55, 1'b1);
            observe_output("ps2 drain");
            cnt++;
         end
      end

      // end code
      drive_byte(8'h00, 1'b1);
      observe_output("end prefix");
      drive_byte(8'h00, 1'b1);
      observe_output("end prefix");
      drive_byte(8'h01, 1'b1);
      observe_output("end prefix");
      drive_byte(END_CODE, 1'b1);
      observe_output("end prefix");
      cnt = 0;
      while (!stream_done)
      begin
         if (cnt == 10)
            report_timeout("stream_done to rise");
         else
         begin
            drive_byte(8'h55, 1'b1);
            observe_output("end wait");
            cnt++;
         end
      end
      // a whole packet after the end code must be ignored
      drive_byte(8'h00, 1'b1);
      observe_output("after end");
      drive_byte(8'h00, 1'b1);
      observe_output("after end");
      drive_byte(8'h01, 1'b1);
      observe_output("after end");
      drive_byte(8'hE0, 1'b1);
      observe_output("after end");
      drive_byte(8'h00, 1'b1);
      observe_output("after end");
      drive_byte(8'h02, 1'b1);
      observe_output("after end");
      drive_byte(8'hAA, 1'b1);
      observe_output("after end");
      check_value("after end stream_done", 64'd1, stream_done);
      drive_byte(8'hBB, 0);
      observe_output("start low");
      cnt = 0;
      while (stream_done)
      begin
         if (cnt == 10)
            report_timeout("stream_done to fall");
         else
         begin
            drive_byte(8'h55, 1'b0);
            observe_output("start low");
            cnt++;
         end
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+tests
logic/mpeg_stream_pkg.sv
logic/start_code_detector.sv
logic/time_stamp_parser.sv
logic/packet_reader.sv
logic/system_stream_parser.sv
tests/system_stream_parser_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the MPEG system stream parser testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 -f sources.f \
   --top-module system_stream_parser_tb -Mdir obj_dir > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vsystem_stream_parser_tb > sim.log 2>&1 || true
grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended early, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
